//--- src/vec_pkg.sv
////////////////////
// Shared widths, types and opcodes of the vector unit
// Elements are 32 bit wide, and memory accesses are word sized
// vl_t has room for up to MaxNrLanes x ElemsPerLane elements
////////////////////

package vec_pkg;

  // Element and bus widths
  localparam int unsigned ElemWidth = 32;
  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [31:0] addr_t;

  // Vector register file geometry
  localparam int unsigned NrVRegs = 8;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  localparam int unsigned ElemsPerLane = 4;
  typedef logic [$clog2(ElemsPerLane)-1:0] lane_elem_t;

  // Lane VRF address is {register, element within lane}
  typedef logic [$bits(vreg_idx_t)+$bits(lane_elem_t)-1:0] vrf_addr_t;

  localparam int unsigned MaxNrLanes = 16;
  typedef logic [7:0] vl_t;

  typedef enum logic [2:0] {
    VSETVL,
    VADD_VV,
    VXOR_VV,
    VADD_VX,
    VLE,
    VSE
  } vec_op_e;

endpackage

//--- src/vec_dispatcher.sv
////////////////////
// Core-facing dispatcher, holds the vector length register
// VSETVL is completed here and never reaches the sequencer
// One instruction in flight, a held response blocks new requests
////////////////////
`timescale 1ns/1ps

module vec_dispatcher #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Core request channel
  input  logic                acc_req_valid_i,
  input  vec_pkg::vec_op_e    acc_req_op_i,
  input  vec_pkg::vreg_idx_t  acc_req_vd_i,
  input  vec_pkg::vreg_idx_t  acc_req_vs1_i,
  input  vec_pkg::vreg_idx_t  acc_req_vs2_i,
  input  vec_pkg::elem_t      acc_req_scalar_i,
  output logic                acc_req_ready_o,
  // Core response channel
  output logic                acc_resp_valid_o,
  output vec_pkg::vl_t        acc_resp_data_o,
  input  logic                acc_resp_ready_i,
  // Sequencer
  output logic                issue_valid_o,
  output vec_pkg::vec_op_e    issue_op_o,
  output vec_pkg::vreg_idx_t  issue_vd_o,
  output vec_pkg::vreg_idx_t  issue_vs1_o,
  output vec_pkg::vreg_idx_t  issue_vs2_o,
  output vec_pkg::elem_t      issue_scalar_o,
  output vec_pkg::vl_t        issue_vl_o,
  input  logic                issue_ready_i,
  input  logic                issue_done_i
);

  localparam int unsigned VLMAX = NrLanes * vec_pkg::ElemsPerLane;

  typedef enum logic [1:0] {DISP_IDLE, DISP_ISSUE, DISP_WAIT, DISP_RESP} disp_state_e;

  disp_state_e  state_q;
  vec_pkg::vl_t vl_q;
  vec_pkg::vl_t vl_clip;

  // Requested length saturated at VLMAX
  assign vl_clip = (acc_req_scalar_i > vec_pkg::elem_t'(VLMAX)) ?
                   vec_pkg::vl_t'(VLMAX) : vec_pkg::vl_t'(acc_req_scalar_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= DISP_IDLE;
      vl_q    <= vec_pkg::vl_t'(VLMAX);
    end else begin
      case (state_q)
        DISP_IDLE: begin
          if (acc_req_valid_i) begin
            if (acc_req_op_i == vec_pkg::VSETVL) begin
              vl_q    <= vl_clip;
              state_q <= DISP_RESP;
            end else begin
              state_q <= DISP_ISSUE;
            end
          end
        end
        DISP_ISSUE: if (issue_ready_i) state_q <= DISP_WAIT;
        DISP_WAIT:  if (issue_done_i) state_q <= DISP_RESP;
        DISP_RESP:  if (acc_resp_ready_i) state_q <= DISP_IDLE;
        default:    state_q <= DISP_IDLE;
      endcase
    end
  end

  // Instruction fields, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (state_q == DISP_IDLE && acc_req_valid_i) begin
      issue_op_o     <= acc_req_op_i;
      issue_vd_o     <= acc_req_vd_i;
      issue_vs1_o    <= acc_req_vs1_i;
      issue_vs2_o    <= acc_req_vs2_i;
      issue_scalar_o <= acc_req_scalar_i;
    end
  end

  assign acc_req_ready_o  = (state_q == DISP_IDLE);
  assign issue_valid_o    = (state_q == DISP_ISSUE);
  assign issue_vl_o       = vl_q;
  // vl_q only changes in idle, so the data holds for the whole response
  assign acc_resp_valid_o = (state_q == DISP_RESP);
  assign acc_resp_data_o  = vl_q;

endmodule

//--- src/vec_sequencer.sv
////////////////////
// Issues one instruction at a time to all lanes or to the VLSU
// Completion is reported once every target has signalled done
////////////////////
`timescale 1ns/1ps

module vec_sequencer #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Dispatcher
  input  logic                issue_valid_i,
  input  vec_pkg::vec_op_e    issue_op_i,
  input  vec_pkg::vreg_idx_t  issue_vd_i,
  input  vec_pkg::vreg_idx_t  issue_vs1_i,
  input  vec_pkg::vreg_idx_t  issue_vs2_i,
  input  vec_pkg::elem_t      issue_scalar_i,
  input  vec_pkg::vl_t        issue_vl_i,
  output logic                issue_ready_o,
  output logic                issue_done_o,
  // Processing elements
  output vec_pkg::vec_op_e    pe_op_o,
  output vec_pkg::vreg_idx_t  pe_vd_o,
  output vec_pkg::vreg_idx_t  pe_vs1_o,
  output vec_pkg::vreg_idx_t  pe_vs2_o,
  output vec_pkg::elem_t      pe_scalar_o,
  output vec_pkg::vl_t        pe_vl_o,
  output logic                lane_valid_o,
  output logic                vlsu_valid_o,
  input  logic [NrLanes-1:0]  lane_ready_i,
  input  logic [NrLanes-1:0]  lane_done_i,
  input  logic                vlsu_ready_i,
  input  logic                vlsu_done_i
);

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_BUSY} seq_state_e;

  seq_state_e         state_q;
  // Bit NrLanes is the VLSU, the others are the lanes
  logic [NrLanes:0]   pending_q;
  logic               new_mem;
  logic               cur_mem;

  assign new_mem = issue_op_i inside {vec_pkg::VLE, vec_pkg::VSE};
  assign cur_mem = pe_op_o inside {vec_pkg::VLE, vec_pkg::VSE};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= SEQ_IDLE;
      pending_q <= '0;
    end else begin
      pending_q <= pending_q & ~{vlsu_done_i, lane_done_i};
      case (state_q)
        SEQ_IDLE: begin
          if (issue_valid_i) begin
            pending_q <= new_mem ? {1'b1, {NrLanes{1'b0}}} : {1'b0, {NrLanes{1'b1}}};
            state_q   <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          if (cur_mem ? vlsu_ready_i : &lane_ready_i) state_q <= SEQ_BUSY;
        end
        SEQ_BUSY: if (pending_q == '0) state_q <= SEQ_IDLE;
        default:  state_q <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == SEQ_IDLE && issue_valid_i) begin
      pe_op_o     <= issue_op_i;
      pe_vd_o     <= issue_vd_i;
      pe_vs1_o    <= issue_vs1_i;
      pe_vs2_o    <= issue_vs2_i;
      pe_scalar_o <= issue_scalar_i;
      pe_vl_o     <= issue_vl_i;
    end
  end

  assign issue_ready_o = (state_q == SEQ_IDLE);
  assign lane_valid_o  = (state_q == SEQ_ISSUE) && !cur_mem;
  assign vlsu_valid_o  = (state_q == SEQ_ISSUE) && cur_mem;
  // One cycle after the last done pulse was cleared from the mask
  assign issue_done_o  = (state_q == SEQ_BUSY) && (pending_q == '0);

endmodule

//--- src/vec_lane.sv
////////////////////
// One lane: a slice of the VRF and an integer element ALU
// Holds elements LaneId, LaneId + NrLanes, ... of every register
// Tail elements at or above vl are left untouched
// The VLSU write port is only honoured while the lane is idle
////////////////////
`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned NrLanes = 2,
  parameter int unsigned LaneId  = 0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Sequencer
  input  vec_pkg::vec_op_e    pe_op_i,
  input  vec_pkg::vreg_idx_t  pe_vd_i,
  input  vec_pkg::vreg_idx_t  pe_vs1_i,
  input  vec_pkg::vreg_idx_t  pe_vs2_i,
  input  vec_pkg::elem_t      pe_scalar_i,
  input  vec_pkg::vl_t        pe_vl_i,
  input  logic                lane_valid_i,
  output logic                lane_ready_o,
  output logic                lane_done_o,
  // VLSU access to the register file
  input  logic                vrf_we_i,
  input  vec_pkg::vrf_addr_t  vrf_waddr_i,
  input  vec_pkg::elem_t      vrf_wdata_i,
  input  vec_pkg::vrf_addr_t  vrf_raddr_i,
  output vec_pkg::elem_t      vrf_rdata_o
);

  localparam int unsigned VrfDepth = vec_pkg::NrVRegs * vec_pkg::ElemsPerLane;
  localparam int unsigned CntOffset = NrLanes - 1 - LaneId;

  typedef logic [$clog2(vec_pkg::ElemsPerLane):0] cnt_t;
  typedef enum logic [1:0] {LANE_IDLE, LANE_RUN, LANE_DONE} lane_state_e;

  lane_state_e          state_q;
  vec_pkg::lane_elem_t  idx_q;
  cnt_t                 cnt_q;
  cnt_t                 elem_cnt;
  vec_pkg::vec_op_e     op_q;
  vec_pkg::vreg_idx_t   vd_q;
  vec_pkg::vreg_idx_t   vs1_q;
  vec_pkg::vreg_idx_t   vs2_q;
  vec_pkg::elem_t       scalar_q;
  logic                 last_elem;

  // Number of indices below vl that map to this lane
  assign elem_cnt  = cnt_t'((32'(pe_vl_i) + CntOffset) / NrLanes);
  assign last_elem = (cnt_t'(idx_q) + cnt_t'(1)) == cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= LANE_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        LANE_IDLE: begin
          if (lane_valid_i) begin
            idx_q   <= '0;
            state_q <= (elem_cnt == '0) ? LANE_DONE : LANE_RUN;
          end
        end
        LANE_RUN: begin
          idx_q <= idx_q + 1'b1;
          if (last_elem) state_q <= LANE_DONE;
        end
        LANE_DONE: state_q <= LANE_IDLE;
        default:   state_q <= LANE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LANE_IDLE && lane_valid_i) begin
      cnt_q    <= elem_cnt;
      op_q     <= pe_op_i;
      vd_q     <= pe_vd_i;
      vs1_q    <= pe_vs1_i;
      vs2_q    <= pe_vs2_i;
      scalar_q <= pe_scalar_i;
    end
  end

  ////////////////////
  // Register file and ALU
  ////////////////////

  vec_pkg::elem_t     vrf_q [VrfDepth];
  vec_pkg::elem_t     opa;
  vec_pkg::elem_t     opb;
  vec_pkg::elem_t     alu_res;
  logic               wr_en;
  vec_pkg::vrf_addr_t wr_addr;
  vec_pkg::elem_t     wr_data;

  assign opa = vrf_q[{vs1_q, idx_q}];
  assign opb = vrf_q[{vs2_q, idx_q}];

  always_comb begin
    case (op_q)
      vec_pkg::VADD_VV: alu_res = opa + opb;
      vec_pkg::VXOR_VV: alu_res = opa ^ opb;
      // vadd.vx adds the scalar to vs2
      vec_pkg::VADD_VX: alu_res = opb + scalar_q;
      default:          alu_res = opb;
    endcase
  end

  always_comb begin
    if (state_q == LANE_RUN) begin
      wr_en   = 1'b1;
      wr_addr = {vd_q, idx_q};
      wr_data = alu_res;
    end else begin
      wr_en   = vrf_we_i;
      wr_addr = vrf_waddr_i;
      wr_data = vrf_wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) vrf_q[wr_addr] <= wr_data;
  end

  assign vrf_rdata_o  = vrf_q[vrf_raddr_i];
  assign lane_ready_o = (state_q == LANE_IDLE);
  assign lane_done_o  = (state_q == LANE_DONE);

endmodule

//--- src/vec_vlsu.sv
////////////////////
// Unit-stride load/store unit with a Wishbone classic master
// One word access per element, from base up to base + 4 x (vl - 1)
// Bus idles for one cycle between accesses
// Stores read vs1, loads write vd
////////////////////
`timescale 1ns/1ps

module vec_vlsu #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Sequencer
  input  vec_pkg::vec_op_e                     pe_op_i,
  input  vec_pkg::vreg_idx_t                   pe_vd_i,
  input  vec_pkg::vreg_idx_t                   pe_vs1_i,
  input  vec_pkg::elem_t                       pe_scalar_i,
  input  vec_pkg::vl_t                         pe_vl_i,
  input  logic                                 vlsu_valid_i,
  output logic                                 vlsu_ready_o,
  output logic                                 vlsu_done_o,
  // Lane register files
  output logic               [NrLanes-1:0]     vrf_we_o,
  output vec_pkg::vrf_addr_t [NrLanes-1:0]     vrf_waddr_o,
  output vec_pkg::elem_t     [NrLanes-1:0]     vrf_wdata_o,
  output vec_pkg::vrf_addr_t                   vrf_raddr_o,
  input  vec_pkg::elem_t     [NrLanes-1:0]     vrf_rdata_i,
  // Wishbone master
  output logic                                 wb_cyc_o,
  output logic                                 wb_stb_o,
  output logic                                 wb_we_o,
  output vec_pkg::addr_t                       wb_adr_o,
  output vec_pkg::elem_t                       wb_dat_o,
  input  vec_pkg::elem_t                       wb_dat_i,
  input  logic                                 wb_ack_i
);

  typedef enum logic [1:0] {LSU_IDLE, LSU_ACCESS, LSU_DONE} lsu_state_e;

  lsu_state_e          state_q;
  logic                cyc_q;
  vec_pkg::vl_t        idx_q;
  vec_pkg::vl_t        vl_q;
  logic                store_q;
  vec_pkg::vreg_idx_t  vd_q;
  vec_pkg::vreg_idx_t  vs1_q;
  vec_pkg::addr_t      base_q;
  vec_pkg::vl_t        lane_sel;
  vec_pkg::lane_elem_t lane_elem;

  // Element i sits in lane i mod NrLanes at index i / NrLanes
  assign lane_sel  = idx_q % vec_pkg::vl_t'(NrLanes);
  assign lane_elem = vec_pkg::lane_elem_t'(idx_q / NrLanes);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= LSU_IDLE;
      cyc_q   <= 1'b0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        LSU_IDLE: begin
          if (vlsu_valid_i) begin
            idx_q <= '0;
            if (pe_vl_i == '0) begin
              state_q <= LSU_DONE;
            end else begin
              cyc_q   <= 1'b1;
              state_q <= LSU_ACCESS;
            end
          end
        end
        LSU_ACCESS: begin
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (wb_ack_i) begin
            cyc_q <= 1'b0;
            if (idx_q == vl_q - 1'b1) state_q <= LSU_DONE;
            else idx_q <= idx_q + 1'b1;
          end
        end
        LSU_DONE: state_q <= LSU_IDLE;
        default:  state_q <= LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LSU_IDLE && vlsu_valid_i) begin
      vl_q    <= pe_vl_i;
      store_q <= (pe_op_i == vec_pkg::VSE);
      vd_q    <= pe_vd_i;
      vs1_q   <= pe_vs1_i;
      base_q  <= vec_pkg::addr_t'(pe_scalar_i);
    end
  end

  ////////////////////
  // Bus and VRF ports
  ////////////////////

  assign wb_cyc_o    = cyc_q;
  assign wb_stb_o    = cyc_q;
  assign wb_we_o     = cyc_q & store_q;
  assign wb_adr_o    = base_q + {idx_q, 2'b00};
  assign vrf_raddr_o = {vs1_q, lane_elem};
  assign wb_dat_o    = vrf_rdata_i[lane_sel];

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane_wr
    assign vrf_we_o[l]    = cyc_q & wb_ack_i & !store_q & (lane_sel == vec_pkg::vl_t'(l));
    assign vrf_waddr_o[l] = {vd_q, lane_elem};
    assign vrf_wdata_o[l] = wb_dat_i;
  end

  assign vlsu_ready_o = (state_q == LSU_IDLE);
  assign vlsu_done_o  = (state_q == LSU_DONE);

endmodule

//--- src/vec_top.sv
////////////////////
// Vector unit top level
// NrLanes must be a power of two and at most MaxNrLanes
// VLMAX is NrLanes x ElemsPerLane, the reset value of vl
////////////////////
`timescale 1ns/1ps

module vec_top #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Core request and response
  input  logic                acc_req_valid_i,
  input  vec_pkg::vec_op_e    acc_req_op_i,
  input  vec_pkg::vreg_idx_t  acc_req_vd_i,
  input  vec_pkg::vreg_idx_t  acc_req_vs1_i,
  input  vec_pkg::vreg_idx_t  acc_req_vs2_i,
  input  vec_pkg::elem_t      acc_req_scalar_i,
  output logic                acc_req_ready_o,
  output logic                acc_resp_valid_o,
  output vec_pkg::vl_t        acc_resp_data_o,
  input  logic                acc_resp_ready_i,
  // Wishbone master
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output vec_pkg::addr_t      wb_adr_o,
  output vec_pkg::elem_t      wb_dat_o,
  input  vec_pkg::elem_t      wb_dat_i,
  input  logic                wb_ack_i
);

  if (NrLanes == 0 || NrLanes != 2**$clog2(NrLanes) || NrLanes > vec_pkg::MaxNrLanes)
  begin : gen_bad_lanes
    $error("vec_top: NrLanes must be a power of two between 1 and MaxNrLanes");
  end

  // Dispatcher to sequencer
  logic               issue_valid;
  logic               issue_ready;
  logic               issue_done;
  vec_pkg::vec_op_e   issue_op;
  vec_pkg::vreg_idx_t issue_vd;
  vec_pkg::vreg_idx_t issue_vs1;
  vec_pkg::vreg_idx_t issue_vs2;
  vec_pkg::elem_t     issue_scalar;
  vec_pkg::vl_t       issue_vl;

  // Sequencer to processing elements
  vec_pkg::vec_op_e   pe_op;
  vec_pkg::vreg_idx_t pe_vd;
  vec_pkg::vreg_idx_t pe_vs1;
  vec_pkg::vreg_idx_t pe_vs2;
  vec_pkg::elem_t     pe_scalar;
  vec_pkg::vl_t       pe_vl;
  logic               lane_valid;
  logic               vlsu_valid;
  logic [NrLanes-1:0] lane_ready;
  logic [NrLanes-1:0] lane_done;
  logic               vlsu_ready;
  logic               vlsu_done;

  // VLSU to lane register files
  logic               [NrLanes-1:0] vrf_we;
  vec_pkg::vrf_addr_t [NrLanes-1:0] vrf_waddr;
  vec_pkg::elem_t     [NrLanes-1:0] vrf_wdata;
  vec_pkg::elem_t     [NrLanes-1:0] vrf_rdata;
  vec_pkg::vrf_addr_t               vrf_raddr;

  vec_dispatcher #(
    .NrLanes(NrLanes)
  ) i_dispatcher (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_op_i     (acc_req_op_i    ),
    .acc_req_vd_i     (acc_req_vd_i    ),
    .acc_req_vs1_i    (acc_req_vs1_i   ),
    .acc_req_vs2_i    (acc_req_vs2_i   ),
    .acc_req_scalar_i (acc_req_scalar_i),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_data_o  (acc_resp_data_o ),
    .acc_resp_ready_i (acc_resp_ready_i),
    .issue_valid_o    (issue_valid     ),
    .issue_op_o       (issue_op        ),
    .issue_vd_o       (issue_vd        ),
    .issue_vs1_o      (issue_vs1       ),
    .issue_vs2_o      (issue_vs2       ),
    .issue_scalar_o   (issue_scalar    ),
    .issue_vl_o       (issue_vl        ),
    .issue_ready_i    (issue_ready     ),
    .issue_done_i     (issue_done      )
  );

  vec_sequencer #(
    .NrLanes(NrLanes)
  ) i_sequencer (
    .clk_i          (clk_i       ),
    .rst_n_i        (rst_n_i     ),
    .issue_valid_i  (issue_valid ),
    .issue_op_i     (issue_op    ),
    .issue_vd_i     (issue_vd    ),
    .issue_vs1_i    (issue_vs1   ),
    .issue_vs2_i    (issue_vs2   ),
    .issue_scalar_i (issue_scalar),
    .issue_vl_i     (issue_vl    ),
    .issue_ready_o  (issue_ready ),
    .issue_done_o   (issue_done  ),
    .pe_op_o        (pe_op       ),
    .pe_vd_o        (pe_vd       ),
    .pe_vs1_o       (pe_vs1      ),
    .pe_vs2_o       (pe_vs2      ),
    .pe_scalar_o    (pe_scalar   ),
    .pe_vl_o        (pe_vl       ),
    .lane_valid_o   (lane_valid  ),
    .vlsu_valid_o   (vlsu_valid  ),
    .lane_ready_i   (lane_ready  ),
    .lane_done_i    (lane_done   ),
    .vlsu_ready_i   (vlsu_ready  ),
    .vlsu_done_i    (vlsu_done   )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes(NrLanes),
      .LaneId (l      )
    ) i_lane (
      .clk_i        (clk_i        ),
      .rst_n_i      (rst_n_i      ),
      .pe_op_i      (pe_op        ),
      .pe_vd_i      (pe_vd        ),
      .pe_vs1_i     (pe_vs1       ),
      .pe_vs2_i     (pe_vs2       ),
      .pe_scalar_i  (pe_scalar    ),
      .pe_vl_i      (pe_vl        ),
      .lane_valid_i (lane_valid   ),
      .lane_ready_o (lane_ready[l]),
      .lane_done_o  (lane_done[l] ),
      .vrf_we_i     (vrf_we[l]    ),
      .vrf_waddr_i  (vrf_waddr[l] ),
      .vrf_wdata_i  (vrf_wdata[l] ),
      .vrf_raddr_i  (vrf_raddr    ),
      .vrf_rdata_o  (vrf_rdata[l] )
    );
  end

  vec_vlsu #(
    .NrLanes(NrLanes)
  ) i_vlsu (
    .clk_i        (clk_i     ),
    .rst_n_i      (rst_n_i   ),
    .pe_op_i      (pe_op     ),
    .pe_vd_i      (pe_vd     ),
    .pe_vs1_i     (pe_vs1    ),
    .pe_scalar_i  (pe_scalar ),
    .pe_vl_i      (pe_vl     ),
    .vlsu_valid_i (vlsu_valid),
    .vlsu_ready_o (vlsu_ready),
    .vlsu_done_o  (vlsu_done ),
    .vrf_we_o     (vrf_we    ),
    .vrf_waddr_o  (vrf_waddr ),
    .vrf_wdata_o  (vrf_wdata ),
    .vrf_raddr_o  (vrf_raddr ),
    .vrf_rdata_i  (vrf_rdata ),
    .wb_cyc_o     (wb_cyc_o  ),
    .wb_stb_o     (wb_stb_o  ),
    .wb_we_o      (wb_we_o   ),
    .wb_adr_o     (wb_adr_o  ),
    .wb_dat_o     (wb_dat_o  ),
    .wb_dat_i     (wb_dat_i  ),
    .wb_ack_i     (wb_ack_i  )
  );

endmodule

//--- bench/vec_top_props.sv
////////////////////
// Handshake properties of vec_top, bound into every instance
// Store data is only checked on writes, load data may be unknown
////////////////////
`timescale 1ns/1ps

module vec_top_props (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           acc_req_ready_o,
  input logic           acc_resp_valid_o,
  input vec_pkg::vl_t   acc_resp_data_o,
  input logic           acc_resp_ready_i,
  input logic           wb_cyc_o,
  input logic           wb_stb_o,
  input logic           wb_we_o,
  input vec_pkg::addr_t wb_adr_o,
  input vec_pkg::elem_t wb_dat_o,
  input logic           wb_ack_i
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> wb_cyc_o)
    else begin
      fail_cnt++;
      $error("Wishbone stb high without cyc");
    end

  // Request held until ack
  bus_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o))
    else begin
      fail_cnt++;
      $error("Wishbone address or we changed while waiting for ack");
    end

  store_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_o && wb_we_o && !wb_ack_i |=> $stable(wb_dat_o))
    else begin
      fail_cnt++;
      $error("Wishbone write data changed while waiting for ack");
    end

  resp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_data_o))
    else begin
      fail_cnt++;
      $error("Response dropped or changed before it was taken");
    end

  req_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o |-> !acc_req_ready_o)
    else begin
      fail_cnt++;
      $error("Request ready high while a response is valid");
    end

endmodule

bind vec_top vec_top_props i_props (
  .clk_i            (clk_i           ),
  .rst_n_i          (rst_n_i         ),
  .acc_req_ready_o  (acc_req_ready_o ),
  .acc_resp_valid_o (acc_resp_valid_o),
  .acc_resp_data_o  (acc_resp_data_o ),
  .acc_resp_ready_i (acc_resp_ready_i),
  .wb_cyc_o         (wb_cyc_o        ),
  .wb_stb_o         (wb_stb_o        ),
  .wb_we_o          (wb_we_o         ),
  .wb_adr_o         (wb_adr_o        ),
  .wb_dat_o         (wb_dat_o        ),
  .wb_ack_i         (wb_ack_i        )
);

//--- bench/vec_tb.sv
////////////////////
// Directed testbench for vec_top with two lanes
// Wishbone memory model of 256 words, address bits above 9 are ignored
// Wait states and test data come from one Galois LFSR
////////////////////
`timescale 1ns/1ps

module vec_tb;

  localparam int unsigned NrLanes  = 2;
  localparam int unsigned VLMAX    = NrLanes * vec_pkg::ElemsPerLane;
  localparam int unsigned MemWords = 256;
  // Under 20 instructions of up to VLMAX elements at about 6 cycles each, with a wide margin
  localparam int unsigned MaxCycles = 20000;

  logic                clk_i;
  logic                rst_n_i;
  logic                acc_req_valid_i;
  vec_pkg::vec_op_e    acc_req_op_i;
  vec_pkg::vreg_idx_t  acc_req_vd_i;
  vec_pkg::vreg_idx_t  acc_req_vs1_i;
  vec_pkg::vreg_idx_t  acc_req_vs2_i;
  vec_pkg::elem_t      acc_req_scalar_i;
  logic                acc_req_ready_o;
  logic                acc_resp_valid_o;
  vec_pkg::vl_t        acc_resp_data_o;
  logic                acc_resp_ready_i;
  logic                wb_cyc_o;
  logic                wb_stb_o;
  logic                wb_we_o;
  vec_pkg::addr_t      wb_adr_o;
  vec_pkg::elem_t      wb_dat_o;
  vec_pkg::elem_t      wb_dat_i;
  logic                wb_ack_i;

  vec_pkg::elem_t mem [MemWords];
  vec_pkg::elem_t src_a [VLMAX];
  vec_pkg::elem_t src_b [VLMAX];
  logic [31:0]    lfsr;
  int unsigned    errors;
  int unsigned    cycles;
  int unsigned    wait_left;
  logic           bus_busy;

  vec_top #(
    .NrLanes(NrLanes)
  ) dut_i (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_op_i     (acc_req_op_i    ),
    .acc_req_vd_i     (acc_req_vd_i    ),
    .acc_req_vs1_i    (acc_req_vs1_i   ),
    .acc_req_vs2_i    (acc_req_vs2_i   ),
    .acc_req_scalar_i (acc_req_scalar_i),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_data_o  (acc_resp_data_o ),
    .acc_resp_ready_i (acc_resp_ready_i),
    .wb_cyc_o         (wb_cyc_o        ),
    .wb_stb_o         (wb_stb_o        ),
    .wb_we_o          (wb_we_o         ),
    .wb_adr_o         (wb_adr_o        ),
    .wb_dat_o         (wb_dat_o        ),
    .wb_dat_i         (wb_dat_i        ),
    .wb_ack_i         (wb_ack_i        )
  );

  always #5 clk_i = ~clk_i;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] next_rand(input int unsigned nbits);
    logic [31:0] val;
    logic        bit_out;
    val = '0;
    for (int unsigned b = 0; b < nbits; b++) begin
      bit_out = lfsr[0];
      lfsr = lfsr >> 1;
      if (bit_out) begin
        lfsr = lfsr ^ 32'h8020_0003;
      end
      val = {val[30:0], bit_out};
    end
    return val;
  endfunction

  task automatic step_cycle();
    @(posedge clk_i);
    #1;
  endtask

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles, a response or a bus ack never came", cycles);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////
  // Wishbone memory
  ////////////////////

  // Ack after 0 to 3 wait states, dropped once the access has ended
  always begin
    step_cycle();
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;
      bus_busy = 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!bus_busy) begin
        bus_busy  = 1'b1;
        wait_left = next_rand(2);
      end
      if (wait_left == 0) begin
        if (wb_we_o) begin
          mem[wb_adr_o[9:2]] = wb_dat_o;
        end else begin
          wb_dat_i = mem[wb_adr_o[9:2]];
        end
        wb_ack_i = 1'b1;
      end else begin
        wait_left--;
      end
    end
  end

  ////////////////////
  // Checks and driving
  ////////////////////

  task automatic check_vl(input string name, input vec_pkg::vl_t exp, input vec_pkg::vl_t act);
    if (act !== exp) begin
      $display("Fail %s: expected vl %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_elem(input string name, input vec_pkg::elem_t exp,
                            input vec_pkg::elem_t act);
    if (act !== exp) begin
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  // Holds the request until it transfers, returns one cycle later
  task automatic send_req(input vec_pkg::vec_op_e op, input vec_pkg::vreg_idx_t vd,
                          input vec_pkg::vreg_idx_t vs1, input vec_pkg::vreg_idx_t vs2,
                          input vec_pkg::elem_t scalar);
    logic accepted;
    acc_req_valid_i  = 1'b1;
    acc_req_op_i     = op;
    acc_req_vd_i     = vd;
    acc_req_vs1_i    = vs1;
    acc_req_vs2_i    = vs2;
    acc_req_scalar_i = scalar;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = acc_req_ready_o;
      step_cycle();
    end
    acc_req_valid_i = 1'b0;
  endtask

  task automatic wait_resp(output vec_pkg::vl_t data);
    while (!acc_resp_valid_o) begin
      step_cycle();
    end
    data = acc_resp_data_o;
    acc_resp_ready_i = 1'b1;
    step_cycle();
  endtask

  task automatic issue_instr(input string name, input vec_pkg::vec_op_e op,
                             input vec_pkg::vreg_idx_t vd, input vec_pkg::vreg_idx_t vs1,
                             input vec_pkg::vreg_idx_t vs2, input vec_pkg::elem_t scalar,
                             input vec_pkg::vl_t exp_vl);
    vec_pkg::vl_t resp;
    send_req(op, vd, vs1, vs2, scalar);
    if (op == vec_pkg::VSETVL && !acc_resp_valid_o) begin
      $display("%s: VSETVL response was not valid one cycle after the request", name);
      errors++;
    end
    wait_resp(resp);
    check_vl(name, exp_vl, resp);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_setvl();
    issue_instr("setvl 3", vec_pkg::VSETVL, 0, 0, 0, 3, 3);
    issue_instr("setvl 100", vec_pkg::VSETVL, 0, 0, 0, 100, VLMAX);
    issue_instr("setvl 0", vec_pkg::VSETVL, 0, 0, 0, 0, 0);
    issue_instr("setvl max", vec_pkg::VSETVL, 0, 0, 0, VLMAX, VLMAX);
  endtask

  // Words 0 to 7 copied to 0x100 through v1
  task automatic test_load_store();
    for (int i = 0; i < VLMAX; i++) begin
      src_a[i] = next_rand(32);
      mem[i]   = src_a[i];
    end
    issue_instr("copy vle", vec_pkg::VLE, 1, 0, 0, 32'h000, VLMAX);
    issue_instr("copy vse", vec_pkg::VSE, 0, 1, 0, 32'h100, VLMAX);
    for (int i = 0; i < VLMAX; i++) begin
      check_elem("copy", src_a[i], mem[64 + i]);
    end
  endtask

  task automatic test_vv_ops();
    for (int i = 0; i < VLMAX; i++) begin
      src_b[i]   = next_rand(32);
      mem[16 + i] = src_b[i];
    end
    issue_instr("vv vle", vec_pkg::VLE, 2, 0, 0, 32'h040, VLMAX);
    issue_instr("vadd.vv", vec_pkg::VADD_VV, 3, 1, 2, 0, VLMAX);
    issue_instr("vxor.vv", vec_pkg::VXOR_VV, 4, 1, 2, 0, VLMAX);
    issue_instr("vv vse sum", vec_pkg::VSE, 0, 3, 0, 32'h200, VLMAX);
    issue_instr("vv vse xor", vec_pkg::VSE, 0, 4, 0, 32'h280, VLMAX);
    for (int i = 0; i < VLMAX; i++) begin
      check_elem("vadd.vv", src_a[i] + src_b[i], mem[128 + i]);
      check_elem("vxor.vv", src_a[i] ^ src_b[i], mem[160 + i]);
    end
  endtask

  // v5 starts as B, only its first 5 elements get A + scalar
  task automatic test_add_vx();
    vec_pkg::elem_t scalar;
    scalar = next_rand(32);
    issue_instr("vx vle", vec_pkg::VLE, 5, 0, 0, 32'h040, VLMAX);
    issue_instr("vx setvl 5", vec_pkg::VSETVL, 0, 0, 0, 5, 5);
    issue_instr("vadd.vx", vec_pkg::VADD_VX, 5, 0, 1, scalar, 5);
    issue_instr("vx setvl max", vec_pkg::VSETVL, 0, 0, 0, VLMAX, VLMAX);
    issue_instr("vx vse", vec_pkg::VSE, 0, 5, 0, 32'h300, VLMAX);
    for (int i = 0; i < VLMAX; i++) begin
      check_elem("vadd.vx", (i < 5) ? src_a[i] + scalar : src_b[i], mem[192 + i]);
    end
  endtask

  task automatic test_backpressure();
    vec_pkg::vl_t held;
    vec_pkg::vl_t resp;
    acc_resp_ready_i = 1'b0;
    send_req(vec_pkg::VSETVL, 0, 0, 0, 6);
    // Second request presented while the first response is held
    acc_req_valid_i  = 1'b1;
    acc_req_scalar_i = VLMAX;
    while (!acc_resp_valid_o) begin
      step_cycle();
    end
    held = acc_resp_data_o;
    check_vl("back-pressure", 6, held);
    repeat (6) begin
      step_cycle();
      if (!acc_resp_valid_o || acc_resp_data_o !== held) begin
        $display("Response valid or data changed while response ready was low");
        errors++;
      end
      if (acc_req_ready_o) begin
        $display("Request ready was high while a response was pending");
        errors++;
      end
    end
    acc_resp_ready_i = 1'b1;
    step_cycle();
    if (acc_resp_valid_o) begin
      $display("Response stayed valid after it was taken");
      errors++;
    end
    send_req(vec_pkg::VSETVL, 0, 0, 0, VLMAX);
    wait_resp(resp);
    check_vl("back-pressure next", VLMAX, resp);
  endtask

  initial begin
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    acc_req_valid_i  = 1'b0;
    acc_req_op_i     = vec_pkg::VSETVL;
    acc_req_vd_i     = '0;
    acc_req_vs1_i    = '0;
    acc_req_vs2_i    = '0;
    acc_req_scalar_i = '0;
    acc_resp_ready_i = 1'b1;
    wb_dat_i         = '0;
    wb_ack_i         = 1'b0;
    lfsr             = 32'h384f_44f8;
    errors           = 0;
    cycles           = 0;
    wait_left        = 0;
    bus_busy         = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = 32'hC0DE_0000 | 32'(i);
    end
    repeat (2) step_cycle();
    rst_n_i = 1'b1;
    if (!acc_req_ready_o || acc_resp_valid_o || wb_cyc_o || wb_stb_o) begin
      $display("Outputs were not idle after reset");
      errors++;
    end
    test_setvl();
    test_load_store();
    test_vv_ops();
    test_add_vx();
    test_backpressure();
    $display("Run finished with %0d check errors and %0d assertion failures",
             errors, dut_i.i_props.fail_cnt);
    if (errors == 0 && dut_i.i_props.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- list.f
src/vec_pkg.sv
src/vec_dispatcher.sv
src/vec_sequencer.sv
src/vec_lane.sv
src/vec_vlsu.sv
src/vec_top.sv
bench/vec_top_props.sv
bench/vec_tb.sv

//--- Bender.yml
package:
  name: vec_unit

sources:
  # Design
  - src/vec_pkg.sv
  - src/vec_dispatcher.sv
  - src/vec_sequencer.sv
  - src/vec_lane.sv
  - src/vec_vlsu.sv
  - src/vec_top.sv

  # Testbench
  - target: test
    files:
      - bench/vec_top_props.sv
      - bench/vec_tb.sv
